// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := tb_axis_converter
FILELIST  := axis_converter.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'ALL CHECKS PASSED'

clean:
	rm -rf $(OBJ_DIR)

// File: axis_converter.f
+incdir+verilog
verilog/axis_converter_pkg.sv
verilog/fifo_if.sv
verilog/fallthrough_fifo.sv
verilog/axis_length_counter.sv
verilog/axis_width_downsizer.sv
verilog/axis_converter.sv
testbench/tb_axis_converter.sv

// File: testbench/tb_axis_converter.sv
`timescale 1ns/1ps
`default_nettype none

`include "axis_converter_cfg.svh"

module tb_axis_converter;

   localparam int num_basic      = 20;
   localparam int num_random     = 30;
   localparam int num_fill       = 40;
   localparam int timeout_cycles = (num_basic + num_random + num_fill) * 64 * 4 + 5000;

   logic                       axi_aclk;
   logic                       axi_resetn;
   logic [`S_DATA_WIDTH-1:0]   s_axis_tdata;
   logic [`S_DATA_WIDTH/8-1:0] s_axis_tstrb;
   logic                       s_axis_tvalid;
   logic                       s_axis_tlast;
   logic                       s_axis_tready;
   logic [`M_DATA_WIDTH-1:0]   m_axis_tdata;
   logic [`M_DATA_WIDTH/8-1:0] m_axis_tstrb;
   logic [`USER_WIDTH-1:0]     m_axis_tuser;
   logic                       m_axis_tvalid;
   logic                       m_axis_tlast;
   logic                       m_axis_tready;

   logic [36:0]           lane_q[$]; // {tlast, tstrb, tdata} per lane
   logic [`LEN_WIDTH-1:0] len_q[$];

   logic                     exp_valid = 1'b0;
   logic                     exp_last  = 1'b0;
   logic [3:0]               exp_strb  = '0;
   logic [31:0]              exp_data  = '0;
   logic [`USER_WIDTH-1:0]   exp_user  = '0;
   logic                     out_xfer  = 1'b0;
   logic                     out_last  = 1'b0;
   int                       errors    = 0;
   int                       pkts_in   = 0;
   int                       pkts_out  = 0;
   int                       ready_mode = 0; // 0 high, 1 random, 2 low

   axis_converter u_axis_converter (.*);

   initial begin
      axi_aclk = 1'b0;
      forever #4 axi_aclk = ~axi_aclk;
   end

   // Output ready pattern driven just after the edge
   initial begin
      m_axis_tready = 1'b0;
      forever begin
         @(posedge axi_aclk);
         #1;
         case (ready_mode)
            0:       m_axis_tready = 1'b1;
            1:       m_axis_tready = 1'($urandom_range(1, 0));
            default: m_axis_tready = 1'b0;
         endcase
      end
   end

   initial begin
      repeat (timeout_cycles) @(posedge axi_aclk);
      $display("timeout after %0d cycles, the run did not finish", timeout_cycles);
      $display("CHECKS FAILED");
      $finish;
   end

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////
   function automatic void update_expected();
      exp_valid = (lane_q.size() > 0);
      if (exp_valid) begin
         {exp_last, exp_strb, exp_data} = lane_q[0];
      end
      if (len_q.size() > 0) begin
         exp_user = {{(`USER_WIDTH - 2*`PORT_WIDTH - `LEN_WIDTH){1'b0}},
                     `DEFAULT_DST_PORT, `DEFAULT_SRC_PORT, len_q[0]};
      end
   endfunction

   // Lanes that carry bytes of an accepted beat
   task automatic push_beat(input logic [63:0] data, input logic [7:0] strb,
                            input logic last, input int len);
      lane_q.push_back({last && (strb[7:4] == 4'b0), strb[3:0], data[31:0]});
      if (strb[7:4] != 4'b0) begin
         lane_q.push_back({last, strb[7:4], data[63:32]});
      end
      if (last) begin
         len_q.push_back(`LEN_WIDTH'(len));
         pkts_in++;
      end
      update_expected();
   endtask

   always @(negedge axi_aclk) begin
      out_xfer <= m_axis_tvalid && m_axis_tready;
      out_last <= m_axis_tlast;
   end

   always @(posedge axi_aclk) begin
      if (out_xfer) begin
         if (out_last) pkts_out++;
         if (lane_q.size() > 0) begin
            if (lane_q[0][36] && len_q.size() > 0) void'(len_q.pop_front());
            void'(lane_q.pop_front());
         end
         update_expected();
      end
   end

   ////////////////////////////////////////
   // Output checks
   ////////////////////////////////////////
   a_lane_expected: assert property (@(negedge axi_aclk) disable iff (!axi_resetn)
      (m_axis_tvalid && m_axis_tready) |-> exp_valid)
      else begin
         errors++;
         $display("output lane sent while no lane was expected");
      end

   a_tdata: assert property (@(negedge axi_aclk) disable iff (!axi_resetn)
      (m_axis_tvalid && m_axis_tready) |-> (m_axis_tdata == exp_data))
      else begin
         errors++;
         $display("error m_axis_tdata expected %h actual %h", exp_data, m_axis_tdata);
      end

   a_tstrb: assert property (@(negedge axi_aclk) disable iff (!axi_resetn)
      (m_axis_tvalid && m_axis_tready) |-> (m_axis_tstrb == exp_strb))
      else begin
         errors++;
         $display("error m_axis_tstrb expected %h actual %h", exp_strb, m_axis_tstrb);
      end

   a_tlast: assert property (@(negedge axi_aclk) disable iff (!axi_resetn)
      (m_axis_tvalid && m_axis_tready) |-> (m_axis_tlast == exp_last))
      else begin
         errors++;
         $display("error m_axis_tlast expected %h actual %h", exp_last, m_axis_tlast);
      end

   a_tuser: assert property (@(negedge axi_aclk) disable iff (!axi_resetn)
      (m_axis_tvalid && m_axis_tready) |-> (m_axis_tuser == exp_user))
      else begin
         errors++;
         $display("error m_axis_tuser expected %h actual %h", exp_user, m_axis_tuser);
      end

   a_stall_stable: assert property (@(negedge axi_aclk) disable iff (!axi_resetn)
      (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(m_axis_tdata) &&
         $stable(m_axis_tstrb) && $stable(m_axis_tlast) && $stable(m_axis_tuser)))
      else begin
         errors++;
         $display("output changed during a stall");
      end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////
   // Starts and ends 1 ns after a rising edge
   task automatic send_packet(input int len);
      logic [63:0] data;
      logic [7:0]  strb;
      int          nbeats;
      int          nb;
      int          gap;
      bit          accepted;
      nbeats = (len + 7) / 8;
      for (int b = 0; b < nbeats; b++) begin
         nb   = (len - 8*b > 8) ? 8 : len - 8*b;
         data = {$urandom, $urandom};
         strb = 8'((1 << nb) - 1);
         s_axis_tdata  = data;
         s_axis_tstrb  = strb;
         s_axis_tlast  = (b == nbeats - 1);
         s_axis_tvalid = 1'b1;
         accepted = 1'b0;
         while (!accepted) begin
            @(negedge axi_aclk);
            accepted = s_axis_tready; // Transfer at the coming edge
            @(posedge axi_aclk);
            #1;
         end
         push_beat(data, strb, b == nbeats - 1, len);
      end
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
      gap = $urandom_range(2, 0);
      repeat (gap) begin
         @(posedge axi_aclk);
         #1;
      end
   endtask

   task automatic wait_drain(input int limit);
      int n;
      n = 0;
      while (lane_q.size() > 0 && n < limit) begin
         @(negedge axi_aclk);
         n++;
      end
      a_drained: assert (lane_q.size() == 0)
         else begin
            errors++;
            $display("%0d lanes still missing after %0d cycles", lane_q.size(), limit);
         end
   endtask

   task automatic report_test(input int num, input string name, input int errs_before);
      $display("test %0d %s: %s", num, name, (errors == errs_before) ? "ok" : "failed");
   endtask

   task automatic run_packets(input int num, input int count, input int mode);
      int errs_before;
      errs_before = errors;
      ready_mode  = mode;
      @(posedge axi_aclk);
      #1;
      for (int i = 0; i < count; i++) send_packet($urandom_range(64, 1));
      wait_drain(count * 64 * 4);
      report_test(num, (mode == 0) ? "lanes, tlast and tuser" : "random back-pressure",
                  errs_before);
   endtask

   task automatic run_fill(input int num);
      int errs_before;
      int cycles;
      bit dropped;
      errs_before = errors;
      ready_mode  = 2;
      @(posedge axi_aclk);
      #1;
      fork
         for (int i = 0; i < num_fill; i++) send_packet($urandom_range(64, 1));
         begin
            cycles  = 0;
            dropped = 1'b0;
            while (!dropped && cycles < 4000) begin
               @(negedge axi_aclk);
               dropped = !s_axis_tready;
               cycles++;
            end
            a_ready_drop: assert (dropped)
               else begin
                  errors++;
                  $display("s_axis_tready never dropped while the output was stalled");
               end
            repeat (20) @(posedge axi_aclk);
            ready_mode = 0; // Release the output
         end
      join
      wait_drain(num_fill * 64 * 4);
      a_pkt_count: assert (pkts_out == pkts_in)
         else begin
            errors++;
            $display("error packets_out expected %h actual %h", pkts_in, pkts_out);
         end
      report_test(num, "full FIFOs", errs_before);
   endtask

   initial begin
      void'($urandom(32'h16dc));
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tstrb  = '0;
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
      repeat (10) @(posedge axi_aclk);
      #1;
      axi_resetn = 1'b1;

      @(negedge axi_aclk);
      a_idle_valid: assert (!m_axis_tvalid)
         else begin
            errors++;
            $display("error m_axis_tvalid expected %h actual %h", 1'b0, m_axis_tvalid);
         end
      a_idle_ready: assert (s_axis_tready)
         else begin
            errors++;
            $display("error s_axis_tready expected %h actual %h", 1'b1, s_axis_tready);
         end
      report_test(1, "state after reset", 0);

      run_packets(2, num_basic, 0);
      run_packets(3, num_random, 1);
      run_fill(4);

      $display("tests 4, packets in %0d, packets out %0d, errors %0d",
               pkts_in, pkts_out, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/axis_converter.sv
`timescale 1ns/1ps
`default_nettype none

`include "axis_converter_cfg.svh"

module axis_converter
   import axis_converter_pkg::*;
(
   input  wire logic                       axi_aclk,
   input  wire logic                       axi_resetn,

   // Input stream, 64 bits
   input  wire logic [`S_DATA_WIDTH-1:0]   s_axis_tdata,
   input  wire logic [`S_DATA_WIDTH/8-1:0] s_axis_tstrb,
   input  wire logic                       s_axis_tvalid,
   input  wire logic                       s_axis_tlast,
   output logic                            s_axis_tready,

   // Output stream, 32 bits with metadata
   output logic [`M_DATA_WIDTH-1:0]        m_axis_tdata,
   output logic [`M_DATA_WIDTH/8-1:0]      m_axis_tstrb,
   output logic [`USER_WIDTH-1:0]          m_axis_tuser,
   output logic                            m_axis_tvalid,
   output logic                            m_axis_tlast,
   input  wire logic                       m_axis_tready
);

   fifo_if #(.T(s_beat_t))  data_q ();
   fifo_if #(.T(pkt_len_t)) info_q ();

   ////////////////////////////////////////
   // Input side
   ////////////////////////////////////////
   axis_length_counter u_length_counter (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tstrb  (s_axis_tstrb),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tlast  (s_axis_tlast),
      .s_axis_tready (s_axis_tready),
      .data_q        (data_q),
      .info_q        (info_q)
   );

   fallthrough_fifo #(.T(s_beat_t), .depth_bits(`DATA_FIFO_DEPTH_BITS)) u_data_fifo (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .q          (data_q)
   );

   // One entry per packet
   fallthrough_fifo #(.T(pkt_len_t), .depth_bits(`INFO_FIFO_DEPTH_BITS)) u_info_fifo (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .q          (info_q)
   );

   ////////////////////////////////////////
   // Output side
   ////////////////////////////////////////
   axis_width_downsizer u_width_downsizer (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .data_q        (data_q),
      .info_q        (info_q),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tstrb  (m_axis_tstrb),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tlast  (m_axis_tlast),
      .m_axis_tready (m_axis_tready)
   );

endmodule

`default_nettype wire

// File: verilog/axis_converter_cfg.svh
`ifndef AXIS_CONVERTER_CFG_SVH
`define AXIS_CONVERTER_CFG_SVH

// Stream widths in bits
`define S_DATA_WIDTH 64
`define M_DATA_WIDTH 32

// Metadata word on tuser
`define USER_WIDTH 128
`define LEN_WIDTH  16
`define PORT_WIDTH 8

`define MAX_PKT_BYTES 1600 // Largest packet accepted

// Depths as address bits. The data FIFO must hold one whole packet
`define DATA_FIFO_DEPTH_BITS $clog2(`MAX_PKT_BYTES / (`S_DATA_WIDTH / 8) + 1)
`define INFO_FIFO_DEPTH_BITS 5

`define DEFAULT_SRC_PORT 8'h01
`define DEFAULT_DST_PORT 8'h04

`endif

// File: verilog/axis_converter_pkg.sv
`default_nettype none

`include "axis_converter_cfg.svh"

package axis_converter_pkg;

   // Strobe vectors of both stream widths
   typedef logic [`S_DATA_WIDTH/8-1:0] s_strb_t;
   typedef logic [`M_DATA_WIDTH/8-1:0] m_strb_t;

   typedef logic [`LEN_WIDTH-1:0] pkt_len_t; // Bytes in one packet

   // One input beat as held in the data FIFO
   typedef struct packed {
      logic                     tlast;
      s_strb_t                  tstrb;
      logic [`S_DATA_WIDTH-1:0] tdata;
   } s_beat_t;

   ////////////////////////////////////////
   // Metadata word, msb first
   ////////////////////////////////////////
   typedef struct packed {
      logic [`USER_WIDTH-2*`PORT_WIDTH-`LEN_WIDTH-1:0] pad;
      logic [`PORT_WIDTH-1:0]                          dst_port;
      logic [`PORT_WIDTH-1:0]                          src_port;
      pkt_len_t                                        len;
   } meta_t;

endpackage

`default_nettype wire

// File: verilog/axis_length_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "axis_converter_cfg.svh"

module axis_length_counter
   import axis_converter_pkg::*;
(
   input  wire logic                     axi_aclk,
   input  wire logic                     axi_resetn,

   input  wire logic [`S_DATA_WIDTH-1:0] s_axis_tdata,
   input  wire s_strb_t                  s_axis_tstrb,
   input  wire logic                     s_axis_tvalid,
   input  wire logic                     s_axis_tlast,
   output logic                          s_axis_tready,

   fifo_if.writer                        data_q,
   fifo_if.writer                        info_q
);

   localparam int s_bytes   = `S_DATA_WIDTH / 8;
   localparam int cnt_width = $clog2(s_bytes) + 1; // Holds 0 to s_bytes

   logic [cnt_width-1:0] beat_bytes;
   pkt_len_t             len_sum;  // Bytes of earlier beats in this packet
   pkt_len_t             len_next;
   logic                 beat_xfer;
   s_beat_t              beat;

   ////////////////////////////////////////
   // Byte count of the current beat
   ////////////////////////////////////////
   // Strobes are packed from lane 0, so highest set bit plus one
   always_comb begin
      beat_bytes = '0;
      for (int i = 0; i < s_bytes; i++) begin
         if (s_axis_tstrb[i]) begin
            beat_bytes = cnt_width'(i + 1);
         end
      end
   end

   assign s_axis_tready = !data_q.nearly_full && !info_q.nearly_full;
   assign beat_xfer     = s_axis_tvalid && s_axis_tready;
   assign len_next      = len_sum + pkt_len_t'(beat_bytes);

   // Beat goes straight into the data FIFO
   assign beat.tlast     = s_axis_tlast;
   assign beat.tstrb     = s_axis_tstrb;
   assign beat.tdata     = s_axis_tdata;
   assign data_q.wr_en   = beat_xfer;
   assign data_q.wr_data = beat;

   // Packet length is written with its last beat
   assign info_q.wr_en   = beat_xfer && s_axis_tlast;
   assign info_q.wr_data = len_next;

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         len_sum <= '0;
      end else if (beat_xfer) begin
         len_sum <= s_axis_tlast ? '0 : len_next; // Restart on packet end
      end
   end

   // A packet never ends on an empty beat
   a_last_has_bytes: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      (beat_xfer && s_axis_tlast) |-> (|s_axis_tstrb)
   );

endmodule

`default_nettype wire

// File: verilog/axis_width_downsizer.sv
`timescale 1ns/1ps
`default_nettype none

`include "axis_converter_cfg.svh"

module axis_width_downsizer
   import axis_converter_pkg::*;
(
   input  wire logic                  axi_aclk,
   input  wire logic                  axi_resetn,

   fifo_if.reader                     data_q,
   fifo_if.reader                     info_q,

   output logic [`M_DATA_WIDTH-1:0]   m_axis_tdata,
   output m_strb_t                    m_axis_tstrb,
   output logic [`USER_WIDTH-1:0]     m_axis_tuser,
   output logic                       m_axis_tvalid,
   output logic                       m_axis_tlast,
   input  wire logic                  m_axis_tready
);

   localparam int ratio     = `S_DATA_WIDTH / `M_DATA_WIDTH; // Lanes per input beat
   localparam int lane_bits = $clog2(ratio);

   s_beat_t                              head;
   meta_t                                meta;
   logic [ratio-1:0][`M_DATA_WIDTH-1:0]  data_lanes;
   m_strb_t [ratio-1:0]                  strb_lanes;

   logic [lane_bits-1:0] lane;      // Lane of the head beat being sent
   logic [lane_bits-1:0] next_lane;
   logic                 last_lane;
   logic                 beat_done; // Head beat leaves with this lane
   logic                 pkt_start; // Next lane opens a packet
   logic                 lane_xfer;

   ////////////////////////////////////////
   // Lane select from the FIFO head
   ////////////////////////////////////////
   assign head       = data_q.rd_data;
   assign data_lanes = head.tdata;
   assign strb_lanes = head.tstrb;

   assign next_lane = lane + 1'b1;
   assign last_lane = (lane == lane_bits'(ratio - 1));

   assign m_axis_tdata = data_lanes[lane];
   assign m_axis_tstrb = strb_lanes[lane];

   // Last lane of the packet when no bytes follow in this beat
   assign m_axis_tlast = head.tlast && (last_lane || !(|strb_lanes[next_lane]));
   assign beat_done    = last_lane || m_axis_tlast;

   // A packet starts only once its length is known
   assign m_axis_tvalid = !data_q.empty && (!pkt_start || !info_q.empty);
   assign lane_xfer     = m_axis_tvalid && m_axis_tready;

   assign data_q.rd_en = lane_xfer && beat_done;
   assign info_q.rd_en = lane_xfer && m_axis_tlast; // Length held for the whole packet

   ////////////////////////////////////////
   // Metadata word
   ////////////////////////////////////////
   always_comb begin
      meta          = '0;
      meta.dst_port = `DEFAULT_DST_PORT;
      meta.src_port = `DEFAULT_SRC_PORT;
      meta.len      = info_q.rd_data;
   end

   assign m_axis_tuser = meta;

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         lane      <= '0;
         pkt_start <= 1'b1;
      end else if (lane_xfer) begin
         lane      <= beat_done ? '0 : next_lane;
         pkt_start <= m_axis_tlast;
      end
   end

   // Outputs hold through a stall
   a_stable_on_stall: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      (m_axis_tvalid && !m_axis_tready) |=>
         (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tstrb) &&
          $stable(m_axis_tlast) && $stable(m_axis_tuser))
   );

endmodule

`default_nettype wire

// File: verilog/fallthrough_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "axis_converter_cfg.svh"

module fallthrough_fifo
   import axis_converter_pkg::*;
#(
   parameter type T          = s_beat_t,
   parameter int  depth_bits = `DATA_FIFO_DEPTH_BITS
) (
   input wire logic axi_aclk,
   input wire logic axi_resetn,
   fifo_if.fifo     q
);

   localparam int unsigned depth = 2 ** depth_bits;

   T ram [depth];

   logic [depth_bits-1:0] wr_ptr;
   logic [depth_bits-1:0] rd_ptr;
   logic [depth_bits:0]   count; // Entries held, 0 to depth
   logic                  full;

   ////////////////////////////////////////
   // Storage
   ////////////////////////////////////////
   always_ff @(posedge axi_aclk) begin
      if (q.wr_en) begin
         ram[wr_ptr] <= q.wr_data;
      end
   end

   assign q.rd_data = ram[rd_ptr]; // Head shows without a read

   ////////////////////////////////////////
   // Pointers and occupancy
   ////////////////////////////////////////
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (q.wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (q.rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({q.wr_en, q.rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count; // Both or neither
         endcase
      end
   end

   assign q.empty       = (count == '0);
   assign full          = (count == (depth_bits + 1)'(depth));
   assign q.nearly_full = (count >= (depth_bits + 1)'(depth - 1));

   // Writers must respect nearly_full, readers must respect empty
   a_no_write_when_full: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      q.wr_en |-> !full
   );

   a_no_read_when_empty: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      q.rd_en |-> !q.empty
   );

endmodule

`default_nettype wire

// File: verilog/fifo_if.sv
`timescale 1ns/1ps
`default_nettype none

// Write and read sides of one FIFO
interface fifo_if #(
   parameter type T = logic
);

   logic wr_en;
   T     wr_data;
   logic nearly_full; // At most one slot left

   logic rd_en;       // Pop the head entry
   T     rd_data;     // Head entry, valid while not empty
   logic empty;

   modport writer (output wr_en, output wr_data, input nearly_full);

   modport fifo (
      input  wr_en,
      input  wr_data,
      input  rd_en,
      output nearly_full,
      output rd_data,
      output empty
   );

   modport reader (output rd_en, input rd_data, input empty);

   modport monitor (input wr_en, wr_data, nearly_full, rd_en, rd_data, empty);

endinterface

`default_nettype wire
